// ==== idu_params.svh ====
// decode stage widths, register count and major opcode values
`ifndef IDU_PARAMS_SVH
`define IDU_PARAMS_SVH

`define IDU_XLEN   64
`define IDU_ILEN   32
`define IDU_REG_AW 5
`define IDU_NREGS  32

`define IDU_OPC_LUI       7'b0110111
`define IDU_OPC_AUIPC     7'b0010111
`define IDU_OPC_JAL       7'b1101111
`define IDU_OPC_JALR      7'b1100111
`define IDU_OPC_BRANCH    7'b1100011
`define IDU_OPC_LOAD      7'b0000011
`define IDU_OPC_STORE     7'b0100011
`define IDU_OPC_OP_IMM    7'b0010011
`define IDU_OPC_OP_IMM_32 7'b0011011
`define IDU_OPC_OP        7'b0110011
`define IDU_OPC_OP_32     7'b0111011
`define IDU_OPC_SYSTEM    7'b1110011

`endif

// ==== idu_pkg.sv ====
// enum types for major opcode, alu operation, branch function, memory size and immediate format
`include "idu_params.svh"

package idu_pkg;

  typedef enum logic [6:0] {
    OPC_LUI       = `IDU_OPC_LUI,
    OPC_AUIPC     = `IDU_OPC_AUIPC,
    OPC_JAL       = `IDU_OPC_JAL,
    OPC_JALR      = `IDU_OPC_JALR,
    OPC_BRANCH    = `IDU_OPC_BRANCH,
    OPC_LOAD      = `IDU_OPC_LOAD,
    OPC_STORE     = `IDU_OPC_STORE,
    OPC_OP_IMM    = `IDU_OPC_OP_IMM,
    OPC_OP_IMM_32 = `IDU_OPC_OP_IMM_32,
    OPC_OP        = `IDU_OPC_OP,
    OPC_OP_32     = `IDU_OPC_OP_32,
    OPC_SYSTEM    = `IDU_OPC_SYSTEM
  } opcode_e;

  // codes shared with the execute stage
  typedef enum logic [4:0] {
    ALU_ADD      = 5'd0,
    ALU_SUB      = 5'd1,
    ALU_SLT      = 5'd2,
    ALU_SLTU     = 5'd3,
    ALU_XOR      = 5'd4,
    ALU_AND      = 5'd5,
    ALU_OR       = 5'd6,
    ALU_SLL      = 5'd7,
    ALU_SRL      = 5'd8,
    ALU_SRA      = 5'd9,
    ALU_MUL      = 5'd10,
    ALU_DIV      = 5'd11,
    ALU_DIVU     = 5'd12,
    ALU_REM      = 5'd13,
    ALU_REMU     = 5'd14,
    ALU_COPY_IMM = 5'd15,
    ALU_MULH     = 5'd25,
    ALU_MULHSU   = 5'd26,
    ALU_MULHU    = 5'd27,
    ALU_INVALID  = 5'd31
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_func_e;

  typedef enum logic [2:0] {
    MEM_B, MEM_BU, MEM_H, MEM_HU, MEM_W, MEM_WU, MEM_D, MEM_NONE
  } mem_op_e;

  typedef enum logic [2:0] {
    IMM_I, IMM_U, IMM_S, IMM_B, IMM_J, IMM_NONE
  } imm_fmt_e;

endpackage

// ==== inst_decoder.sv ====
// RV64IM instruction classification and control field generation
`include "idu_params.svh"

module inst_decoder
  import idu_pkg::*;
(
  input  logic [`IDU_ILEN-1:0] i_inst,
  output imm_fmt_e             o_imm_fmt,
  output alu_op_e              o_alu_op,
  output logic                 o_alu_a_src,
  output logic [1:0]           o_alu_b_src,
  output logic                 o_word_cut,
  output logic                 o_bren,
  output br_func_e             o_br_func,
  output logic                 o_mem_re,
  output logic                 o_mem_wr,
  output mem_op_e              o_mem_op,
  output logic                 o_reg_wr,
  output logic                 o_invalid_inst
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f3_add_sr; // funct3 of add/sub or srl/sra
  logic       hit;
  logic       is_r, is_i, is_u, is_s, is_b, is_j;
  logic       is_jalr, is_load, any_fmt;

  function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  function automatic alu_op_e m_op(input logic [2:0] f3);
    alu_op_e op;
    case (f3)
      3'b000:  op = ALU_MUL;
      3'b001:  op = ALU_MULH;
      3'b010:  op = ALU_MULHSU;
      3'b011:  op = ALU_MULHU;
      3'b100:  op = ALU_DIV;
      3'b101:  op = ALU_DIVU;
      3'b110:  op = ALU_REM;
      default: op = ALU_REMU;
    endcase
    return op;
  endfunction

  assign opcode    = opcode_e'(i_inst[6:0]);
  assign funct3    = i_inst[14:12];
  assign funct7    = i_inst[31:25];
  assign f3_add_sr = (funct3 == 3'b000) || (funct3 == 3'b101);

  always_comb begin
    hit       = 1'b0;
    o_alu_op  = ALU_INVALID; // branches keep this
    o_br_func = BR_JAL;
    o_mem_op  = MEM_NONE;
    case (opcode)
      OPC_LUI: begin
        hit      = 1'b1;
        o_alu_op = ALU_COPY_IMM;
      end
      OPC_AUIPC: begin
        hit      = 1'b1;
        o_alu_op = ALU_ADD;
      end
      OPC_JAL: begin
        hit       = 1'b1;
        o_alu_op  = ALU_ADD;
        o_br_func = BR_JAL;
      end
      OPC_JALR: begin
        hit       = (funct3 == 3'b000);
        o_alu_op  = ALU_ADD;
        o_br_func = BR_JALR;
      end
      OPC_BRANCH: begin
        hit = (funct3[2:1] != 2'b01);
        case (funct3)
          3'b000:  o_br_func = BR_BEQ;
          3'b001:  o_br_func = BR_BNE;
          3'b100:  o_br_func = BR_BLT;
          3'b101:  o_br_func = BR_BGE;
          3'b110:  o_br_func = BR_BLTU;
          default: o_br_func = BR_BGEU;
        endcase
      end
      OPC_LOAD: begin
        hit      = (funct3 != 3'b111);
        o_alu_op = ALU_ADD; // address calc
        case (funct3)
          3'b000:  o_mem_op = MEM_B;
          3'b001:  o_mem_op = MEM_H;
          3'b010:  o_mem_op = MEM_W;
          3'b011:  o_mem_op = MEM_D;
          3'b100:  o_mem_op = MEM_BU;
          3'b101:  o_mem_op = MEM_HU;
          3'b110:  o_mem_op = MEM_WU;
          default: o_mem_op = MEM_NONE;
        endcase
      end
      OPC_STORE: begin
        hit      = !funct3[2];
        o_alu_op = ALU_ADD;
        case (funct3[1:0])
          2'b00:   o_mem_op = MEM_B;
          2'b01:   o_mem_op = MEM_H;
          2'b10:   o_mem_op = MEM_W;
          default: o_mem_op = MEM_D;
        endcase
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'b001:  hit = (funct7[6:1] == 6'b000000);
          3'b101:  hit = (funct7[6:1] == 6'b000000) || (funct7[6:1] == 6'b010000);
          default: hit = 1'b1;
        endcase
        o_alu_op = base_op(funct3, (funct3 == 3'b101) && funct7[5]);
      end
      OPC_OP_IMM_32: begin
        case (funct3)
          3'b000:  hit = 1'b1;
          3'b001:  hit = (funct7 == 7'b0000000);
          3'b101:  hit = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          default: hit = 1'b0;
        endcase
        o_alu_op = base_op(funct3, (funct3 == 3'b101) && funct7[5]);
      end
      OPC_OP: begin
        case (funct7)
          7'b0000000: begin
            hit      = 1'b1;
            o_alu_op = base_op(funct3, 1'b0);
          end
          7'b0100000: begin
            hit      = f3_add_sr;
            o_alu_op = base_op(funct3, 1'b1);
          end
          7'b0000001: begin
            hit      = 1'b1;
            o_alu_op = m_op(funct3);
          end
          default: hit = 1'b0;
        endcase
      end
      OPC_OP_32: begin
        case (funct7)
          7'b0000000: begin
            hit      = f3_add_sr || (funct3 == 3'b001);
            o_alu_op = base_op(funct3, 1'b0);
          end
          7'b0100000: begin
            hit      = f3_add_sr;
            o_alu_op = base_op(funct3, 1'b1);
          end
          7'b0000001: begin
            hit      = (funct3 == 3'b000) || funct3[2]; // mulw, div/rem w
            o_alu_op = m_op(funct3);
          end
          default: hit = 1'b0;
        endcase
      end
      OPC_SYSTEM: hit = 1'b0; // no csr or trap support
      default:    hit = 1'b0;
    endcase
    if (!hit) begin
      o_alu_op = ALU_INVALID;
      o_mem_op = MEM_NONE;
    end
  end

  assign is_r    = hit && (opcode == OPC_OP || opcode == OPC_OP_32);
  assign is_i    = hit && (opcode == OPC_JALR || opcode == OPC_LOAD ||
                           opcode == OPC_OP_IMM || opcode == OPC_OP_IMM_32);
  assign is_u    = hit && (opcode == OPC_LUI || opcode == OPC_AUIPC);
  assign is_s    = hit && (opcode == OPC_STORE);
  assign is_b    = hit && (opcode == OPC_BRANCH);
  assign is_j    = hit && (opcode == OPC_JAL);
  assign is_jalr = hit && (opcode == OPC_JALR);
  assign is_load = hit && (opcode == OPC_LOAD);
  assign any_fmt = is_r || is_i || is_u || is_s || is_b || is_j;

  assign o_imm_fmt = is_i ? IMM_I :
                     is_u ? IMM_U :
                     is_s ? IMM_S :
                     is_b ? IMM_B :
                     is_j ? IMM_J : IMM_NONE;

  assign o_alu_a_src    = is_j || is_jalr || (hit && opcode == OPC_AUIPC); // pc
  assign o_alu_b_src    = {is_j || is_jalr, (is_i || is_u || is_s) && !is_jalr};
  assign o_word_cut     = hit && (opcode == OPC_OP_IMM_32 || opcode == OPC_OP_32);
  assign o_reg_wr       = is_r || is_i || is_u || is_j;
  assign o_bren         = is_b || is_j || is_jalr;
  assign o_mem_re       = is_load;
  assign o_mem_wr       = is_s;
  assign o_invalid_inst = !any_fmt && (i_inst != '0); // all-zero word passes

endmodule

// ==== imm_gen.sv ====
// sign-extended immediate assembly for I, U, S, B and J formats
`include "idu_params.svh"

module imm_gen
  import idu_pkg::*;
(
  input  logic [`IDU_ILEN-1:0] i_inst,
  input  imm_fmt_e             i_fmt,
  output logic [`IDU_XLEN-1:0] o_imm
);

  logic sign;

  assign sign = i_inst[31];

  always_comb begin
    case (i_fmt)
      IMM_I: o_imm = {{(`IDU_XLEN-12){sign}}, i_inst[31:20]};
      IMM_U: o_imm = {{(`IDU_XLEN-32){sign}}, i_inst[31:12], 12'b0};
      IMM_S: o_imm = {{(`IDU_XLEN-12){sign}}, i_inst[31:25], i_inst[11:7]};
      IMM_B: begin
        o_imm = {{(`IDU_XLEN-13){sign}}, i_inst[31], i_inst[7],
                 i_inst[30:25], i_inst[11:8], 1'b0};
      end
      IMM_J: begin
        o_imm = {{(`IDU_XLEN-21){sign}}, i_inst[31], i_inst[19:12],
                 i_inst[20], i_inst[30:21], 1'b0};
      end
      default: o_imm = '0; // no immediate
    endcase
  end

endmodule

// ==== gpr_file.sv ====
// 32 x 64-bit register file with two async reads and one sync write
`include "idu_params.svh"

module gpr_file (
  input  logic                   i_clk,
  input  logic [`IDU_REG_AW-1:0] i_raddr1,
  input  logic [`IDU_REG_AW-1:0] i_raddr2,
  input  logic [`IDU_REG_AW-1:0] i_waddr,
  input  logic                   i_wen,
  input  logic [`IDU_XLEN-1:0]   i_wdata,
  output logic [`IDU_XLEN-1:0]   o_rdata1,
  output logic [`IDU_XLEN-1:0]   o_rdata2
);

  logic [`IDU_XLEN-1:0] regs [`IDU_NREGS];

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin // x0 stays zero
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== idu_top.sv ====
// decode stage top with instruction register, decoder, immediate generator and register file
`include "idu_params.svh"

module idu_top
  import idu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_ifu_ready,
  input  logic [`IDU_ILEN-1:0]   i_inst,
  input  logic                   i_wb_wen,
  input  logic [`IDU_REG_AW-1:0] i_wb_waddr,
  input  logic [`IDU_XLEN-1:0]   i_wb_wdata,
  output logic [`IDU_REG_AW-1:0] o_rd,
  output logic [`IDU_XLEN-1:0]   o_rs1_data,
  output logic [`IDU_XLEN-1:0]   o_rs2_data,
  output logic [`IDU_XLEN-1:0]   o_imm,
  output alu_op_e                o_alu_op,
  output logic                   o_alu_a_src,
  output logic [1:0]             o_alu_b_src,
  output logic                   o_word_cut,
  output logic                   o_bren,
  output br_func_e               o_br_func,
  output logic                   o_mem_re,
  output logic                   o_mem_wr,
  output mem_op_e                o_mem_op,
  output logic                   o_reg_wr,
  output logic                   o_invalid_inst
);

  logic [`IDU_ILEN-1:0] inst_q;
  imm_fmt_e             imm_fmt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      inst_q <= '0;
    end else if (i_ifu_ready) begin // hold while fetch not ready
      inst_q <= i_inst;
    end
  end

  assign o_rd = inst_q[11:7];

  inst_decoder u_dec (
    .i_inst         (inst_q),
    .o_imm_fmt      (imm_fmt),
    .o_alu_op       (o_alu_op),
    .o_alu_a_src    (o_alu_a_src),
    .o_alu_b_src    (o_alu_b_src),
    .o_word_cut     (o_word_cut),
    .o_bren         (o_bren),
    .o_br_func      (o_br_func),
    .o_mem_re       (o_mem_re),
    .o_mem_wr       (o_mem_wr),
    .o_mem_op       (o_mem_op),
    .o_reg_wr       (o_reg_wr),
    .o_invalid_inst (o_invalid_inst)
  );

  imm_gen u_imm (
    .i_inst (inst_q),
    .i_fmt  (imm_fmt),
    .o_imm  (o_imm)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_raddr1 (inst_q[19:15]), // rs1
    .i_raddr2 (inst_q[24:20]), // rs2
    .i_waddr  (i_wb_waddr),
    .i_wen    (i_wb_wen),
    .i_wdata  (i_wb_wdata),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

endmodule

// ==== tb_clkgen.sv ====
// testbench clock and reset source
module tb_clkgen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk; // period 40
  end

  initial begin
    o_rst = 1'b1;
    repeat (8) @(posedge o_clk);
    #5;
    o_rst = 1'b0;
  end

endmodule

// ==== tb_idu.sv ====
// vector-driven testbench top for the decode stage
`include "idu_params.svh"

module tb_idu;

  logic                   clk;
  logic                   rst;
  logic                   ifu_ready;
  logic [`IDU_ILEN-1:0]   inst;
  logic                   wb_wen;
  logic [`IDU_REG_AW-1:0] wb_waddr;
  logic [`IDU_XLEN-1:0]   wb_wdata;
  logic [`IDU_REG_AW-1:0] rd;
  logic [`IDU_XLEN-1:0]   rs1_data;
  logic [`IDU_XLEN-1:0]   rs2_data;
  logic [`IDU_XLEN-1:0]   imm;
  logic [4:0]             alu_op;
  logic [1:0]             b_src;
  logic [2:0]             br_func;
  logic [2:0]             mem_op;
  logic                   a_src, word_cut, bren, mem_re, mem_wr, reg_wr, invalid;
  string                  lines[$];
  int                     errors;
  int                     checks;
  int                     cycles;
  int                     limit;

  tb_clkgen u_clk (
    .o_clk (clk),
    .o_rst (rst)
  );

  idu_top DUT (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_ifu_ready    (ifu_ready),
    .i_inst         (inst),
    .i_wb_wen       (wb_wen),
    .i_wb_waddr     (wb_waddr),
    .i_wb_wdata     (wb_wdata),
    .o_rd           (rd),
    .o_rs1_data     (rs1_data),
    .o_rs2_data     (rs2_data),
    .o_imm          (imm),
    .o_alu_op       (alu_op),
    .o_alu_a_src    (a_src),
    .o_alu_b_src    (b_src),
    .o_word_cut     (word_cut),
    .o_bren         (bren),
    .o_br_func      (br_func),
    .o_mem_re       (mem_re),
    .o_mem_wr       (mem_wr),
    .o_mem_op       (mem_op),
    .o_reg_wr       (reg_wr),
    .o_invalid_inst (invalid)
  );

  task automatic compare_field(input string test, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", test, field, exp, act);
    end
  endtask

  task automatic write_register(input string line);
    logic [63:0] addr;
    logic [63:0] value;
    if ($sscanf(line, "w %h %h", addr, value) != 2) begin
      errors++;
      $display("malformed write line: %s", line);
    end else begin
      wb_wen   = 1'b1;
      wb_waddr = addr[`IDU_REG_AW-1:0];
      wb_wdata = value;
      @(posedge clk);
      #5;
      wb_wen = 1'b0;
    end
  endtask

  task automatic apply_decode_check(input string line);
    string       t;
    logic [63:0] rdy, ins, e_alu, e_a, e_b, e_wc, e_bren, e_brf;
    logic [63:0] e_re, e_wr, e_mop, e_rw, e_inv, e_rd, e_imm, e_rs1, e_rs2;
    int          n;
    n = $sscanf(line, "c %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                t, rdy, ins, e_alu, e_a, e_b, e_wc, e_bren, e_brf, e_re, e_wr,
                e_mop, e_rw, e_inv, e_rd, e_imm, e_rs1, e_rs2);
    if (n != 18) begin
      errors++;
      $display("malformed check line: %s", line);
    end else begin
      ifu_ready = rdy[0];
      inst      = ins[`IDU_ILEN-1:0];
      @(posedge clk); // load edge
      #5;
      ifu_ready = 1'b0;
      checks++;
      compare_field(t, "alu_op", e_alu, 64'(alu_op));
      compare_field(t, "alu_a_src", e_a, 64'(a_src));
      compare_field(t, "alu_b_src", e_b, 64'(b_src));
      compare_field(t, "word_cut", e_wc, 64'(word_cut));
      compare_field(t, "bren", e_bren, 64'(bren));
      compare_field(t, "br_func", e_brf, 64'(br_func));
      compare_field(t, "mem_re", e_re, 64'(mem_re));
      compare_field(t, "mem_wr", e_wr, 64'(mem_wr));
      compare_field(t, "mem_op", e_mop, 64'(mem_op));
      compare_field(t, "reg_wr", e_rw, 64'(reg_wr));
      compare_field(t, "invalid_inst", e_inv, 64'(invalid));
      compare_field(t, "rd", e_rd, 64'(rd));
      compare_field(t, "imm", e_imm, imm);
      compare_field(t, "rs1_data", e_rs1, rs1_data);
      compare_field(t, "rs2_data", e_rs2, rs2_data);
    end
  endtask

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int    fd;
    string line;
    string kind;
    ifu_ready = 1'b0;
    inst      = '0;
    wb_wen    = 1'b0;
    wb_waddr  = '0;
    wb_wdata  = '0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    limit     = 0;
    fd = $fopen("idu_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open idu_vectors.txt");
    end
    while (fd != 0 && !$feof(fd)) begin
      if ($fgets(line, fd) > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
        lines.push_back(line);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    limit = lines.size() * 4 + 100;
    wait (rst == 1'b0);
    @(posedge clk);
    #5; // drive just after the edge
    foreach (lines[i]) begin
      void'($sscanf(lines[i], "%s", kind));
      if (kind == "w") begin
        write_register(lines[i]);
      end else if (kind == "c") begin
        apply_decode_check(lines[i]);
      end else begin
        errors++;
        $display("unknown vector line: %s", lines[i]);
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== idu_vectors.txt ====
# w <reg> <value> | c <name> <ready> <inst> <alu_op> <a_src> <b_src> <word_cut> <bren> <br_func>
#   <mem_re> <mem_wr> <mem_op> <reg_wr> <invalid> <rd> <imm> <rs1_data> <rs2_data>, all hex
c reset 0 00000000 1f 0 0 0 0 0 0 0 7 0 0 00 0 0 0
w 01 8000000000000001
w 02 22
w 03 ffffffffffffff00
w 08 0808080808080808
w 1d 1d1d1d1d1d1d1d1d
w 1f 1f1f1f1f1f1f1f1f
w 00 deadbeef
c add 1 00208233 00 0 0 0 0 0 0 0 7 1 0 04 0 8000000000000001 22
c sub 1 401182b3 01 0 0 0 0 0 0 0 7 1 0 05 0 ffffffffffffff00 8000000000000001
c add_x0 1 00000333 00 0 0 0 0 0 0 0 7 1 0 06 0 0 0
c mulh 1 022093b3 19 0 0 0 0 0 0 0 7 1 0 07 0 8000000000000001 22
c addiw 1 fff0841b 00 0 1 1 0 0 0 0 7 1 0 08 ffffffffffffffff 8000000000000001 1f1f1f1f1f1f1f1f
c sraw 1 4021d4bb 09 0 0 1 0 0 0 0 7 1 0 09 0 ffffffffffffff00 22
c lui 1 80000537 0f 0 1 0 0 0 0 0 7 1 0 0a ffffffff80000000 0 0
c auipc 1 12345597 00 1 1 0 0 0 0 0 7 1 0 0b 12345000 0808080808080808 ffffffffffffff00
c addi 1 80010613 00 0 1 0 0 0 0 0 7 1 0 0c fffffffffffff800 22 0
c jal 1 ffdff0ef 00 1 2 0 1 0 0 0 7 1 0 01 fffffffffffffffc 1f1f1f1f1f1f1f1f 1d1d1d1d1d1d1d1d
c jalr 1 00808067 00 1 2 0 1 1 0 0 7 1 0 00 8 8000000000000001 0808080808080808
c beq 1 fe208ce3 1f 0 0 0 1 2 0 0 7 0 0 19 fffffffffffffff8 8000000000000001 22
c bne 1 00019863 1f 0 0 0 1 3 0 0 7 0 0 10 10 ffffffffffffff00 0
c blt 1 0020c0e3 1f 0 0 0 1 4 0 0 7 0 0 01 800 8000000000000001 22
c bge 1 80115063 1f 0 0 0 1 5 0 0 7 0 0 00 fffffffffffff000 22 8000000000000001
c bltu 1 0011e263 1f 0 0 0 1 6 0 0 7 0 0 04 4 ffffffffffffff00 8000000000000001
c bgeu 1 0230f063 1f 0 0 0 1 7 0 0 7 0 0 00 20 8000000000000001 ffffffffffffff00
c lb 1 fff08683 00 0 1 0 0 0 1 0 0 1 0 0d ffffffffffffffff 8000000000000001 1f1f1f1f1f1f1f1f
c lh 1 00009683 00 0 1 0 0 0 1 0 2 1 0 0d 0 8000000000000001 0
c lw 1 0000a683 00 0 1 0 0 0 1 0 4 1 0 0d 0 8000000000000001 0
c ld 1 0000b683 00 0 1 0 0 0 1 0 6 1 0 0d 0 8000000000000001 0
c lbu 1 0000c683 00 0 1 0 0 0 1 0 1 1 0 0d 0 8000000000000001 0
c lhu 1 0000d683 00 0 1 0 0 0 1 0 3 1 0 0d 0 8000000000000001 0
c lwu 1 0000e683 00 0 1 0 0 0 1 0 5 1 0 0d 0 8000000000000001 0
c sb 1 fe208e23 00 0 1 0 0 0 0 1 0 0 0 1c fffffffffffffffc 8000000000000001 22
c sh 1 00209423 00 0 1 0 0 0 0 1 2 0 0 08 8 8000000000000001 22
c sw 1 0020a023 00 0 1 0 0 0 0 1 4 0 0 00 0 8000000000000001 22
c sd 1 0020b023 00 0 1 0 0 0 0 1 6 0 0 00 0 8000000000000001 22
c ecall 1 00000073 1f 0 0 0 0 0 0 0 7 0 1 00 0 0 0
c undef 1 ffffffff 1f 0 0 0 0 0 0 0 7 0 1 1f 0 1f1f1f1f1f1f1f1f 1f1f1f1f1f1f1f1f
c hold 0 00208233 1f 0 0 0 0 0 0 0 7 0 1 1f 0 1f1f1f1f1f1f1f1f 1f1f1f1f1f1f1f1f

// ==== flist.f ====
+incdir+.
idu_pkg.sv
inst_decoder.sv
imm_gen.sv
gpr_file.sv
idu_top.sv
tb_clkgen.sv
tb_idu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_idu -o tb_idu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_idu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "\*\*\* PASSED \*\*\*" sim.log; then
  exit 0
fi
exit 1
